/* verilog/lsuPkg.sv */
package lsuPkg;

    // ==========================================================
    // Widths
    // ==========================================================
    // Data and address width
    localparam int xlen = 32;

    // Bytes per data word, one byte enable each
    localparam int numLanes = 4;

    // Register index width
    localparam int regAddrWidth = 5;

    // ==========================================================
    // Encodings
    // ==========================================================
    // Access size and signedness, same codes as RISC-V funct3
    typedef enum logic [2:0] {
        opByte  = 3'b000,
        opHalf  = 3'b001,
        opWord  = 3'b010,
        opByteU = 3'b100,
        opHalfU = 3'b101
    } memOp_e;

    // Writeback source select
    typedef enum logic [1:0] {
        srcAlu = 2'b00,
        srcMem = 2'b01,
        srcPc4 = 2'b10
    } resultSrc_e;

    // ==========================================================
    // Pipeline items
    // ==========================================================
    // Executed instruction entering M1
    typedef struct packed {
        logic                    valid;
        logic                    regWrite;
        logic                    memWrite;
        resultSrc_e              resultSrc;
        memOp_e                  op;
        logic [regAddrWidth-1:0] rd;
        logic [xlen-1:0]         aluResult;
        logic [xlen-1:0]         writeData;
        logic [xlen-1:0]         pcPlus4;
    } exItem_t;

    // Item handed from M1 to M2, store data already consumed
    typedef struct packed {
        logic                    valid;
        logic                    regWrite;
        resultSrc_e              resultSrc;
        memOp_e                  op;
        logic [regAddrWidth-1:0] rd;
        logic [xlen-1:0]         aluResult;
        logic [xlen-1:0]         pcPlus4;
    } memItem_t;

    // Register write leaving W
    typedef struct packed {
        logic                    write;
        logic [regAddrWidth-1:0] rd;
        logic [xlen-1:0]         data;
    } wbWrite_t;

endpackage

/* verilog/memRequestStage.sv */
`timescale 1ns/10ps

module memRequestStage
    import lsuPkg::*;
(
    input  logic                clk,
    input  logic                reset,

    // Executed instruction from the environment
    input  exItem_t             ex,

    // Data memory request
    output logic [xlen-1:0]     memAddr,
    output logic [xlen-1:0]     memWriteData,
    output logic [numLanes-1:0] memByteEn,

    // Item passed on to M2
    output memItem_t            m1Item
);

    exItem_t             m1Reg;
    logic [1:0]          addrOffset;
    logic [xlen-1:0]     laneData;
    logic [numLanes-1:0] laneEn;

    // ==========================================================
    // EX/M1 register
    // ==========================================================
    // No stall, so a new item is taken on every edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            m1Reg <= '0;
        end else begin
            m1Reg <= ex;
        end
    end

    // ==========================================================
    // Store alignment
    // ==========================================================
    assign addrOffset = m1Reg.aluResult[1:0];

    always_comb begin
        case (m1Reg.op)
            opByte: begin
                // Byte moves into the addressed lane, rest zero
                laneData = xlen'(m1Reg.writeData[7:0]) << {addrOffset, 3'b000};
                laneEn   = numLanes'(1) << addrOffset;
            end
            opHalf: begin
                // Address bit 1 picks the upper half
                if (addrOffset[1]) begin
                    laneData = {m1Reg.writeData[15:0], 16'b0};
                    laneEn   = 4'b1100;
                end else begin
                    laneData = {16'b0, m1Reg.writeData[15:0]};
                    laneEn   = 4'b0011;
                end
            end
            opWord: begin
                laneData = m1Reg.writeData;
                laneEn   = 4'b1111;
            end
            default: begin
                // Unsigned or undefined sizes never write
                laneData = m1Reg.writeData;
                laneEn   = '0;
            end
        endcase
    end

    // ==========================================================
    // Memory request and M1 item
    // ==========================================================
    assign memAddr      = m1Reg.aluResult;
    assign memWriteData = laneData;

    // Only a valid store may touch memory
    assign memByteEn = (m1Reg.valid && m1Reg.memWrite) ? laneEn : '0;

    always_comb begin
        m1Item.valid     = m1Reg.valid;
        m1Item.regWrite  = m1Reg.regWrite;
        m1Item.resultSrc = m1Reg.resultSrc;
        m1Item.op        = m1Reg.op;
        m1Item.rd        = m1Reg.rd;
        m1Item.aluResult = m1Reg.aluResult;
        m1Item.pcPlus4   = m1Reg.pcPlus4;
    end

endmodule

/* verilog/loadWriteback.sv */
`timescale 1ns/10ps

module loadWriteback
    import lsuPkg::*;
(
    input  logic            clk,
    input  logic            reset,

    // Item leaving M1
    input  memItem_t        m1Item,

    // Word returned by the data memory, one cycle after the request
    input  logic [xlen-1:0] memReadData,

    // Register write of the item in W
    output wbWrite_t        wb
);

    memItem_t        m2Reg;
    memItem_t        wReg;
    logic [1:0]      byteOffset;
    logic [7:0]      loadByte;
    logic [15:0]     loadHalf;
    logic [xlen-1:0] loadData;
    logic [xlen-1:0] wLoadData;

    // ==========================================================
    // M1/M2 register
    // ==========================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            m2Reg <= '0;
        end else begin
            m2Reg <= m1Item;
        end
    end

    // ==========================================================
    // M2 load extraction
    // ==========================================================
    assign byteOffset = m2Reg.aluResult[1:0];

    // Addressed byte and halfword of the returned word
    assign loadByte = memReadData[{byteOffset, 3'b000} +: 8];
    assign loadHalf = byteOffset[1] ? memReadData[31:16] : memReadData[15:0];

    always_comb begin
        case (m2Reg.op)
            opByte: begin
                loadData = {{(xlen - 8){loadByte[7]}}, loadByte};
            end
            opByteU: begin
                loadData = {{(xlen - 8){1'b0}}, loadByte};
            end
            opHalf: begin
                loadData = {{(xlen - 16){loadHalf[15]}}, loadHalf};
            end
            opHalfU: begin
                loadData = {{(xlen - 16){1'b0}}, loadHalf};
            end
            default: begin
                // Word loads and unknown sizes take the whole word
                loadData = memReadData;
            end
        endcase
    end

    // ==========================================================
    // M2/W register
    // ==========================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wReg <= '0;
        end else begin
            wReg <= m2Reg;
        end
    end

    // Load result travels alongside the item
    always_ff @(posedge clk) begin
        wLoadData <= loadData;
    end

    // ==========================================================
    // W result select
    // ==========================================================
    always_comb begin
        case (wReg.resultSrc)
            srcMem: begin
                wb.data = wLoadData;
            end
            srcPc4: begin
                // Link value for jal and jalr
                wb.data = wReg.pcPlus4;
            end
            default: begin
                wb.data = wReg.aluResult;
            end
        endcase
    end

    // Bubbles never write the register file
    assign wb.write = wReg.valid && wReg.regWrite;
    assign wb.rd    = wReg.rd;

endmodule

/* verilog/lsuPipeline.sv */
`timescale 1ns/10ps

module lsuPipeline
    import lsuPkg::*;
(
    input  logic                clk,
    input  logic                reset,

    // Executed instruction, sampled every edge
    input  exItem_t             ex,

    // Data memory request
    output logic [xlen-1:0]     memAddr,
    output logic [xlen-1:0]     memWriteData,
    output logic [numLanes-1:0] memByteEn,

    // Data memory response, one cycle latency
    input  logic [xlen-1:0]     memReadData,

    // Register write out of W
    output wbWrite_t            wb
);

    // Item between M1 and the M1/M2 register
    memItem_t m1Item;

    // ==========================================================
    // M1 request stage
    // ==========================================================
    memRequestStage memRequestStage_inst (
        .clk          (clk),
        .reset        (reset),
        .ex           (ex),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memByteEn    (memByteEn),
        .m1Item       (m1Item)
    );

    // ==========================================================
    // M2 extraction and writeback
    // ==========================================================
    loadWriteback loadWriteback_inst (
        .clk         (clk),
        .reset       (reset),
        .m1Item      (m1Item),
        .memReadData (memReadData),
        .wb          (wb)
    );

endmodule

/* tb/lsuPipeline_props.sv */
`timescale 1ns/10ps

module lsuPipelineProps
    import lsuPkg::*;
(
    input logic                clk,
    input logic                reset,
    input exItem_t             ex,
    input logic [numLanes-1:0] memByteEn,
    input wbWrite_t            wb
);

    // Lanes only open for a valid store sampled at the previous edge
    noStrayEnables: assert property (
        @(posedge clk) disable iff (reset)
        !$past(ex.valid && ex.memWrite) |-> (memByteEn == '0)
    ) else $error("memByteEn set without a valid store in M1");

    byteStoreOneHot: assert property (
        @(posedge clk) disable iff (reset)
        $past(ex.valid && ex.memWrite && ex.op == opByte) |-> $onehot(memByteEn)
    ) else $error("byte store enables more than one lane");

    noWriteInReset: assert property (
        @(posedge clk) reset |-> !wb.write
    ) else $error("register write during reset");

endmodule

bind lsuPipeline lsuPipelineProps lsuPipelineProps_inst (
    .clk       (clk),
    .reset     (reset),
    .ex        (ex),
    .memByteEn (memByteEn),
    .wb        (wb)
);

/* tb/lsuPipelineTb.sv */
`timescale 1ns/10ps

module lsuPipelineTb
    import lsuPkg::*;
();

    logic                clk;
    logic                reset;
    exItem_t             ex;
    logic [xlen-1:0]     memAddr;
    logic [xlen-1:0]     memWriteData;
    logic [numLanes-1:0] memByteEn;
    logic [xlen-1:0]     memReadData = '0;
    wbWrite_t            wb;

    // Data memory and the expected image of it
    logic [xlen-1:0]     dmem [0:63];
    logic [xlen-1:0]     shadow [0:63];

    integer              seed;
    int                  edgeCount = 0;

    // Expected request and writeback, in issue order
    int                  reqCycle [$];
    logic [xlen-1:0]     reqAddr [$];
    logic [numLanes-1:0] reqEn [$];
    logic [xlen-1:0]     reqData [$];
    int                  wbCycle [$];
    wbWrite_t            wbExp [$];

    lsuPipeline lsuPipeline_inst (
        .clk          (clk),
        .reset        (reset),
        .ex           (ex),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memByteEn    (memByteEn),
        .memReadData  (memReadData),
        .wb           (wb)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        edgeCount <= edgeCount + 1;
    end

    // ==========================================================
    // Data memory model, one cycle read latency
    // ==========================================================
    initial begin
        for (int i = 0; i < 64; i++) begin
            // Every byte carries the word index
            dmem[i]   <= {4{2'b10, i[5:0]}};
            shadow[i] = {4{2'b10, i[5:0]}};
        end
    end

    always @(posedge clk) begin
        for (int lane = 0; lane < numLanes; lane++) begin
            if (memByteEn[lane]) begin
                dmem[memAddr[7:2]][8*lane +: 8] <= memWriteData[8*lane +: 8];
            end
        end
        memReadData <= dmem[memAddr[7:2]];
    end

    // ==========================================================
    // Checking
    // ==========================================================
    task automatic checkValue(input string name, input logic [xlen-1:0] actual,
                              input logic [xlen-1:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] time %0t: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Compares outputs with the queued expectations once stable
    always @(negedge clk) begin
        if (reqCycle.size() > 0 && reqCycle[0] == edgeCount) begin
            checkValue("memAddr", memAddr, reqAddr[0]);
            checkValue("memByteEn", xlen'(memByteEn), xlen'(reqEn[0]));
            checkValue("memWriteData", memWriteData, reqData[0]);
            void'(reqCycle.pop_front());
            void'(reqAddr.pop_front());
            void'(reqEn.pop_front());
            void'(reqData.pop_front());
        end
        if (wbCycle.size() > 0 && wbCycle[0] == edgeCount) begin
            checkValue("wb.write", xlen'(wb.write), xlen'(wbExp[0].write));
            checkValue("wb.rd", xlen'(wb.rd), xlen'(wbExp[0].rd));
            checkValue("wb.data", wb.data, wbExp[0].data);
            void'(wbCycle.pop_front());
            void'(wbExp.pop_front());
        end
    end

    task automatic waitForDrain();
        int waited;
        waited = 0;
        while ((reqCycle.size() != 0 || wbCycle.size() != 0) && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        if (reqCycle.size() != 0 || wbCycle.size() != 0) begin
            $display("Timeout: the pipeline did not deliver every expected result");
            $display("*** FAILED ***");
            $fatal(1, "Pipeline drain timeout");
        end
    endtask

    task automatic compareMemory();
        for (int i = 0; i < 64; i++) begin
            checkValue($sformatf("dmem[%0d]", i), dmem[i], shadow[i]);
        end
    endtask

    // ==========================================================
    // Reference rules
    // ==========================================================
    function automatic logic [numLanes-1:0] expectedEnables(input exItem_t item);
        logic [1:0] offset;
        offset = item.aluResult[1:0];
        if (!(item.valid && item.memWrite)) begin
            return '0;
        end
        case (item.op)
            opByte:  return 4'b0001 << offset;
            opHalf:  return offset[1] ? 4'b1100 : 4'b0011;
            opWord:  return 4'b1111;
            default: return '0;
        endcase
    endfunction

    function automatic logic [xlen-1:0] alignedData(input exItem_t item);
        logic [xlen-1:0] data;
        logic [1:0]      offset;
        offset = item.aluResult[1:0];
        data   = '0;
        case (item.op)
            opByte: begin
                for (int lane = 0; lane < numLanes; lane++) begin
                    if (lane == offset) begin
                        data[8*lane +: 8] = item.writeData[7:0];
                    end
                end
            end
            opHalf:  data = offset[1] ? {item.writeData[15:0], 16'h0}
                                      : {16'h0, item.writeData[15:0]};
            default: data = item.writeData;
        endcase
        return data;
    endfunction

    function automatic logic [xlen-1:0] extractLoad(input logic [xlen-1:0] word,
                                                    input memOp_e op,
                                                    input logic [1:0] offset);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (8 * offset));
        h = 16'(word >> (offset[1] ? 16 : 0));
        case (op)
            opByte:  return {{24{b[7]}}, b};
            opByteU: return {24'h0, b};
            opHalf:  return {{16{h[15]}}, h};
            opHalfU: return {16'h0, h};
            default: return word;
        endcase
    endfunction

    function automatic exItem_t buildItem(input logic valid, input logic regWrite,
                                          input logic memWrite, input resultSrc_e src,
                                          input memOp_e op,
                                          input logic [regAddrWidth-1:0] rd,
                                          input logic [xlen-1:0] alu,
                                          input logic [xlen-1:0] wdata,
                                          input logic [xlen-1:0] pc4);
        exItem_t item;
        item.valid     = valid;
        item.regWrite  = regWrite;
        item.memWrite  = memWrite;
        item.resultSrc = src;
        item.op        = op;
        item.rd        = rd;
        item.aluResult = alu;
        item.writeData = wdata;
        item.pcPlus4   = pc4;
        return item;
    endfunction

    // Issues one item and queues what it must produce
    task automatic sendItem(input exItem_t item);
        wbWrite_t            expWrite;
        logic [numLanes-1:0] lanes;
        logic [xlen-1:0]     laneData;
        int                  idx;
        idx            = int'(item.aluResult[7:2]);
        lanes          = expectedEnables(item);
        laneData       = alignedData(item);
        expWrite.write = item.valid && item.regWrite;
        expWrite.rd    = item.rd;
        case (item.resultSrc)
            srcMem:  expWrite.data = extractLoad(shadow[idx], item.op, item.aluResult[1:0]);
            srcPc4:  expWrite.data = item.pcPlus4;
            default: expWrite.data = item.aluResult;
        endcase
        for (int lane = 0; lane < numLanes; lane++) begin
            if (lanes[lane]) begin
                shadow[idx][8*lane +: 8] = laneData[8*lane +: 8];
            end
        end
        @(posedge clk);
        ex <= item;
        // Sampled at the next edge, wb two edges after that
        reqCycle.push_back(edgeCount + 2);
        reqAddr.push_back(item.aluResult);
        reqEn.push_back(lanes);
        reqData.push_back(laneData);
        wbCycle.push_back(edgeCount + 4);
        wbExp.push_back(expWrite);
    endtask

    // ==========================================================
    // Directed tests
    // ==========================================================
    task automatic resetSequence();
        repeat (2) begin
            @(negedge clk);
            checkValue("memByteEn", xlen'(memByteEn), '0);
            checkValue("wb.write", xlen'(wb.write), '0);
        end
        // Third rising edge under reset
        @(posedge clk);
        reset <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            checkValue("memByteEn", xlen'(memByteEn), '0);
            checkValue("wb.write", xlen'(wb.write), '0);
        end
    endtask

    task automatic storeAlignment();
        logic [xlen-1:0] base;
        base = {24'h0, 6'($random(seed)), 2'b00};
        for (int off = 0; off < 4; off++) begin
            sendItem(buildItem(1, 0, 1, srcAlu, opByte, '0, base + xlen'(off),
                               xlen'($random(seed)), '0));
        end
        sendItem(buildItem(1, 0, 1, srcAlu, opHalf, '0, base, xlen'($random(seed)), '0));
        sendItem(buildItem(1, 0, 1, srcAlu, opHalf, '0, base + 2, xlen'($random(seed)), '0));
        sendItem(buildItem(1, 0, 1, srcAlu, opWord, '0, base, xlen'($random(seed)), '0));
        // Items that must not enable any lane
        sendItem(buildItem(0, 0, 1, srcAlu, opWord, '0, base, xlen'($random(seed)), '0));
        sendItem(buildItem(1, 1, 0, srcAlu, opWord, 5'd3, base, xlen'($random(seed)), '0));
        sendItem(buildItem(1, 0, 1, srcAlu, opByteU, '0, base, xlen'($random(seed)), '0));
        sendItem(buildItem(1, 0, 1, srcAlu, memOp_e'(3'b011), '0, base,
                           xlen'($random(seed)), '0));
        sendItem(buildItem(1, 0, 1, srcAlu, memOp_e'(3'b111), '0, base,
                           xlen'($random(seed)), '0));
        sendItem('0);
        waitForDrain();
    endtask

    task automatic loadExtraction();
        memOp_e loadOps [5];
        loadOps = '{opByte, opByteU, opHalf, opHalfU, opWord};
        for (int w = 8; w < 12; w++) begin
            sendItem(buildItem(1, 0, 1, srcAlu, opWord, '0, xlen'(w * 4),
                               xlen'($random(seed)), '0));
        end
        for (int w = 8; w < 12; w++) begin
            for (int k = 0; k < 5; k++) begin
                for (int off = 0; off < 4; off++) begin
                    sendItem(buildItem(1, 1, 0, srcMem, loadOps[k],
                                       regAddrWidth'($random(seed)), xlen'(w * 4 + off),
                                       '0, xlen'($random(seed))));
                end
            end
        end
        sendItem('0);
        waitForDrain();
    endtask

    task automatic resultSelection();
        resultSrc_e src;
        for (int k = 0; k < 8; k++) begin
            src = k[0] ? srcPc4 : srcAlu;
            // Bits 1 and 2 walk through valid and regWrite
            sendItem(buildItem(k[1], k[2], 0, src, opWord, regAddrWidth'($random(seed)),
                               xlen'($random(seed)), xlen'($random(seed)),
                               xlen'($random(seed))));
        end
        sendItem('0);
        waitForDrain();
    endtask

    task automatic backToBack();
        memOp_e          storeOps [3];
        memOp_e          loadOps [5];
        logic [xlen-1:0] addr;
        resultSrc_e      src;
        storeOps = '{opByte, opHalf, opWord};
        loadOps  = '{opByte, opByteU, opHalf, opHalfU, opWord};
        for (int i = 0; i < 12; i++) begin
            addr = {24'h0, 2'b01, 4'(i), 2'($random(seed))};
            src  = $random(seed) & 1 ? srcPc4 : srcAlu;
            sendItem(buildItem(1, 0, 1, srcAlu, storeOps[$unsigned($random(seed)) % 3],
                               '0, addr, xlen'($random(seed)), '0));
            sendItem(buildItem(1, 1, 0, srcMem, loadOps[$unsigned($random(seed)) % 5],
                               regAddrWidth'($random(seed)), addr, '0, '0));
            sendItem(buildItem(1, 1, 0, src, opWord, regAddrWidth'($random(seed)),
                               xlen'($random(seed)), '0, xlen'($random(seed))));
        end
        sendItem('0);
        waitForDrain();
        compareMemory();
    endtask

    initial begin
        seed  = 64;
        reset = 1'b1;
        ex    = '0;
        resetSequence();
        storeAlignment();
        loadExtraction();
        resultSelection();
        backToBack();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* project.f */
verilog/lsuPkg.sv
verilog/memRequestStage.sv
verilog/loadWriteback.sv
verilog/lsuPipeline.sv
tb/lsuPipeline_props.sv
tb/lsuPipelineTb.sv
